// ==== Bender.yml ====
package:
  name: pci_bridge

export_include_dirs:
  - .

sources:
  - pciBridgePkg.sv
  - pciCycleCatch.sv
  - pciCommandEncode.sv
  - pciInitiatorFsm.sv
  - pciBridgeTop.sv
  - target: simulation
    files:
      - pciBridge_assert.sv
      - pciBridge_tb.sv

// ==== filelist.f ====
+incdir+.
pciBridgePkg.sv
pciCycleCatch.sv
pciCommandEncode.sv
pciInitiatorFsm.sv
pciBridgeTop.sv
pciBridge_assert.sv
pciBridge_tb.sv

// ==== pciBridgePkg.sv ====
// PCI bridge types
// Request, command and lane word definitions

`default_nettype none

`include "pciBridge_consts.svh"

package pciBridgePkg;

  // CPU side access type, from the PCIAT pins
  typedef enum logic [1:0] {
    ACC_CONFIG0 = 2'b00,
    ACC_CONFIG1 = 2'b01,
    ACC_MEMORY  = 2'b10,
    ACC_IO      = 2'b11
  } accessType;

  // Bus commands the initiator can issue
  typedef enum logic [3:0] {
    CMD_IO_READ   = `PCI_CMD_IO_READ,
    CMD_IO_WRITE  = `PCI_CMD_IO_WRITE,
    CMD_MEM_READ  = `PCI_CMD_MEM_READ,
    CMD_MEM_WRITE = `PCI_CMD_MEM_WRITE,
    CMD_CFG_READ  = `PCI_CMD_CFG_READ,
    CMD_CFG_WRITE = `PCI_CMD_CFG_WRITE
  } pciCommand;

  // Active low byte lane enables, lowest lane in the top bit
  typedef struct packed {
    logic lowLow;
    logic lowMid;
    logic upMid;
    logic upUp;
  } byteEnables;

  // CBE lane word
  // Command in the address phase, byte enables in the data phase
  typedef union packed {
    pciCommand  cmd;
    byteEnables lanes;
  } cbeWord;

  // Captured CPU request
  typedef struct packed {
    accessType  access;
    logic       read;
    logic [1:0] addrLow;
    logic       burst;
    byteEnables lanes;
  } pciRequest;

endpackage

`default_nettype wire

// ==== pciBridgeTop.sv ====
// CPU to PCI bridge initiator

`timescale 1ns/1ps
`default_nettype none

module pciBridgeTop import pciBridgePkg::*; (
  input  wire             CLK40,
  input  wire             RESETn,
  // CPU side
  input  wire             TSn,
  input  wire             BPRO_ENn,
  input  wire             RnW,
  input  wire             BURST,
  input  wire accessType  pciat,
  input  wire [1:0]       A,
  input  wire byteEnables lanes,
  // PCI target responses
  input  wire             DEVSELn,
  input  wire             TRDYn,
  // PCI initiator outputs
  output logic            FRAMEn,
  output logic            IRDYn,
  output cbeWord          CBE,
  output logic [1:0]      AD,
  output logic            adOe,
  // CPU status
  output logic            pciCycleN,
  output logic            transferAckN,
  output logic            transferErrN
);

  logic       pending;
  logic       accept;
  pciRequest  request;
  cbeWord     addrCbe;
  cbeWord     dataCbe;
  logic [1:0] adLow;

  // Start detect and request hold
  pciCycleCatch catchInst (
    .CLK40    (CLK40),
    .RESETn   (RESETn),
    .TSn      (TSn),
    .BPRO_ENn (BPRO_ENn),
    .RnW      (RnW),
    .BURST    (BURST),
    .pciat    (pciat),
    .A        (A),
    .lanes    (lanes),
    .accept   (accept),
    .pending  (pending),
    .request  (request)
  );

  // Request to command, AD bits and lanes
  pciCommandEncode encodeInst (
    .request (request),
    .addrCbe (addrCbe),
    .dataCbe (dataCbe),
    .adLow   (adLow)
  );

  pciInitiatorFsm fsmInst (
    .CLK40        (CLK40),
    .RESETn       (RESETn),
    .pending      (pending),
    .burst        (request.burst),
    .addrCbe      (addrCbe),
    .dataCbe      (dataCbe),
    .adLowIn      (adLow),
    .DEVSELn      (DEVSELn),
    .TRDYn        (TRDYn),
    .accept       (accept),
    .FRAMEn       (FRAMEn),
    .IRDYn        (IRDYn),
    .CBE          (CBE),
    .AD           (AD),
    .adOe         (adOe),
    .pciCycleN    (pciCycleN),
    .transferAckN (transferAckN),
    .transferErrN (transferErrN)
  );

endmodule

`default_nettype wire

// ==== pciBridge_assert.sv ====
// PCI bridge protocol checks

`timescale 1ns/1ps
`default_nettype none

module pciBridgeAssert (
  input wire CLK40,
  input wire RESETn,
  input wire transferAckN,
  input wire transferErrN,
  input wire adOe,
  input wire IRDYn,
  input wire pciCycleN
);

  // Failures seen so far, read by the testbench at the end
  int failCount = 0;

  // CPU gets either an acknowledge or an error, never both
  ackErrExclusive: assert property (@(posedge CLK40) disable iff (!RESETn)
    !(!transferAckN && !transferErrN))
    else begin
      failCount++;
      $error("acknowledge and error strobes low in the same cycle");
    end

  // AD is released for the whole data phase
  adReleasedInData: assert property (@(posedge CLK40) disable iff (!RESETn)
    !IRDYn |-> !adOe)
    else begin
      failCount++;
      $error("AD driven while IRDYn is low");
    end

  // Data phase only inside a PCI cycle
  irdyInsideCycle: assert property (@(posedge CLK40) disable iff (!RESETn)
    pciCycleN |-> IRDYn)
    else begin
      failCount++;
      $error("IRDYn low outside a PCI cycle");
    end

endmodule

bind pciBridgeTop pciBridgeAssert assertInst (
  .CLK40        (CLK40),
  .RESETn       (RESETn),
  .transferAckN (transferAckN),
  .transferErrN (transferErrN),
  .adOe         (adOe),
  .IRDYn        (IRDYn),
  .pciCycleN    (pciCycleN)
);

`default_nettype wire

// ==== pciBridge_consts.svh ====
// PCI bridge constants
// Bus commands, burst and timeout values

`ifndef PCI_BRIDGE_CONSTS_SVH
`define PCI_BRIDGE_CONSTS_SVH

// PCI bus command codes on CBE in the address phase
`define PCI_CMD_IO_READ    4'b0010
`define PCI_CMD_IO_WRITE   4'b0011
`define PCI_CMD_MEM_READ   4'b0110
`define PCI_CMD_MEM_WRITE  4'b0111
`define PCI_CMD_CFG_READ   4'b1010
`define PCI_CMD_CFG_WRITE  4'b1011

// Lane word for reads, every byte lane enabled
`define PCI_LANES_ALL      4'b0000

// Width of the beat and DEVSEL wait counters
`define PCI_COUNT_W        3

// Beats in one burst line
`define PCI_BURST_BEATS    3'd4

// Data phase cycles allowed before a master abort
`define PCI_DEVSEL_TIMEOUT 3'd5

`endif

// ==== pciBridge_tb.sv ====
// PCI bridge initiator testbench
// Random CPU transfers against a simple PCI target model

`timescale 1ns/1ps
`default_nettype none

`include "pciBridge_consts.svh"

module pciBridge_tb import pciBridgePkg::*; ();

  localparam int TxnCount    = 200;
  localparam int WatchCycles = 10 + TxnCount * 60;

  logic CLK40 = 1'b0;
  logic RESETn, TSn, BPRO_ENn, RnW, BURST, DEVSELn, TRDYn;
  logic [1:0] A, AD;
  accessType pciat;
  byteEnables lanes;
  cbeWord CBE;
  logic FRAMEn, IRDYn, adOe, pciCycleN, transferAckN, transferErrN;

  // Current transaction, shared by stimulus, target model and checker
  logic [31:0] lcgState = 32'd67203;
  logic noResp;
  int devDelay;
  int waitSt [0:3];
  int errors = 0;

  pciBridgeTop uut (.*);

  always #10 CLK40 = ~CLK40;

  // LCG for all random choices
  function automatic logic [15:0] lcgNext();
    lcgState = lcgState * 32'd1103515245 + 32'd12345;
    return lcgState[30:15];
  endfunction

  // Expected {command, AD low bits, data lane word}
  function automatic logic [9:0] refEncode(input logic [1:0] acc, input logic rd,
                                           input logic [1:0] addr, input logic [3:0] ln);
    logic [3:0] cmd;
    case (acc)
      2'b10:   cmd = rd ? 4'b0110 : 4'b0111;
      2'b11:   cmd = rd ? 4'b0010 : 4'b0011;
      default: cmd = rd ? 4'b1010 : 4'b1011;
    endcase
    // Config cycles put the config type on AD[1:0]
    return {cmd, acc[1] ? addr : acc, rd ? 4'b0000 : ln};
  endfunction

  task automatic reportMismatch(input string testName, input logic [31:0] expVal,
                                input logic [31:0] actVal);
    errors++;
    $display("error %s: expected %0h, actual %0h at %0t", testName, expVal, actVal, $time);
  endtask

  ////////////////////////////////////////////////////////////
  // PCI target model, drives 2 ns after the edge
  ////////////////////////////////////////////////////////////

  int dataCyc = 0;
  int beatIdx = 0;
  int waitCnt = 0;

  always @(posedge CLK40) begin
    #2;
    if (pciCycleN) begin
      dataCyc = 0;
      beatIdx = 0;
      waitCnt = 0;
    end
    // Ack low means a beat finished on this edge
    if (!transferAckN) begin
      beatIdx = beatIdx + 1;
      waitCnt = 0;
    end
    if (!IRDYn && !noResp && dataCyc >= devDelay) begin
      DEVSELn = 1'b0;
      TRDYn   = (waitCnt < waitSt[beatIdx]);
      waitCnt = waitCnt + 1;
    end else begin
      DEVSELn = 1'b1;
      TRDYn   = 1'b1;
    end
    if (!IRDYn) dataCyc = dataCyc + 1;
  end

  ////////////////////////////////////////////////////////////
  // Checker, samples at the rising edge
  ////////////////////////////////////////////////////////////

  int cyc = 0;
  int startCyc = 0;
  int beatsSeen, acks, errPulses, nBeats;
  logic inTxn = 1'b0;
  logic lastCycleN = 1'b1;
  logic [9:0] expected;

  always @(posedge CLK40) begin
    cyc = cyc + 1;
    if (RESETn === 1'b1) begin
      if (!TSn && !BPRO_ENn) begin
        startCyc  = cyc;
        inTxn     = 1'b1;
        expected  = refEncode(pciat, RnW, A, lanes);
        nBeats    = BURST ? `PCI_BURST_BEATS : 1;
        beatsSeen = 0;
        acks      = 0;
        errPulses = 0;
      end
      // Address phase starts exactly two edges after the start edge
      if (inTxn && cyc == startCyc + 2 && FRAMEn !== 1'b1)
        reportMismatch("frame early", 1, FRAMEn);
      if (inTxn && cyc == startCyc + 3) begin
        if (FRAMEn !== 1'b0) reportMismatch("frame start", 0, FRAMEn);
        if (CBE !== expected[9:6]) reportMismatch("address command", expected[9:6], CBE);
        if (AD !== expected[5:4]) reportMismatch("address bits", expected[5:4], AD);
        if (adOe !== 1'b1) reportMismatch("address drive", 1, adOe);
      end
      if (inTxn && IRDYn === 1'b0) begin
        if (CBE !== expected[3:0]) reportMismatch("data lanes", expected[3:0], CBE);
        // FRAMEn high only in the last beat
        if (FRAMEn !== (beatsSeen == nBeats - 1))
          reportMismatch("frame last beat", beatsSeen == nBeats - 1, FRAMEn);
        if (!DEVSELn && !TRDYn) beatsSeen++;
      end
      if (transferAckN === 1'b0) acks++;
      if (transferErrN === 1'b0) errPulses++;
      if (inTxn && pciCycleN && !lastCycleN) begin
        inTxn = 1'b0;
        if (acks != (noResp ? 0 : nBeats)) reportMismatch("ack count", noResp ? 0 : nBeats, acks);
        if (errPulses != (noResp ? 1 : 0)) reportMismatch("error pulses", noResp, errPulses);
      end
    end
    lastCycleN = pciCycleN;
  end

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////

  task automatic runTransaction();
    noResp   = (lcgNext() % 8 == 0);
    devDelay = lcgNext() % 4;
    for (int i = 0; i < 4; i++) waitSt[i] = lcgNext() % 4;
    pciat    = accessType'(lcgNext() % 4);
    RnW      = lcgNext() % 2;
    A        = lcgNext() % 4;
    lanes    = byteEnables'(lcgNext() % 16);
    BURST    = lcgNext() % 2;
    TSn      = 1'b0;
    BPRO_ENn = 1'b0;
    @(posedge CLK40);
    #2;
    TSn      = 1'b1;
    BPRO_ENn = 1'b1;
    // Cycle ends when pciCycleN rises again
    wait (pciCycleN == 1'b0);
    wait (pciCycleN == 1'b1);
    @(posedge CLK40);
    #2;
  endtask

  initial begin
    RESETn = 1'b0;
    TSn = 1'b1;
    BPRO_ENn = 1'b1;
    RnW = 1'b1;
    BURST = 1'b0;
    pciat = ACC_MEMORY;
    A = 2'b00;
    lanes = byteEnables'(4'b0000);
    DEVSELn = 1'b1;
    TRDYn = 1'b1;
    noResp = 1'b0;
    devDelay = 0;
    for (int i = 0; i < 4; i++) waitSt[i] = 0;
    repeat (10) @(posedge CLK40);
    #2;
    RESETn = 1'b1;
    // Idle levels after reset
    if ({FRAMEn, IRDYn, pciCycleN, transferAckN, transferErrN, adOe} !== 6'b111110)
      reportMismatch("reset levels", 6'b111110,
                     {FRAMEn, IRDYn, pciCycleN, transferAckN, transferErrN, adOe});
    // Start outside the PCI window
    TSn = 1'b0;
    @(posedge CLK40);
    #2;
    TSn = 1'b1;
    repeat (6) begin
      @(posedge CLK40);
      #2;
      if (pciCycleN !== 1'b1) reportMismatch("window off cycle", 1, pciCycleN);
    end
    for (int t = 0; t < TxnCount; t++) runTransaction();
    repeat (4) @(posedge CLK40);
    $display("checks done: %0d errors, %0d assertion failures", errors,
             uut.assertInst.failCount);
    if (errors == 0 && uut.assertInst.failCount == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  // Watchdog
  initial begin
    repeat (WatchCycles) @(posedge CLK40);
    $display("watchdog: the run did not finish in time");
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

`default_nettype wire

// ==== pciCommandEncode.sv ====
// PCI command and lane encoder

`timescale 1ns/1ps
`default_nettype none

`include "pciBridge_consts.svh"

module pciCommandEncode import pciBridgePkg::*; (
  input  wire pciRequest request,
  output cbeWord         addrCbe,
  output cbeWord         dataCbe,
  output logic [1:0]     adLow
);

  ////////////////////////////////////////////////////////////
  // Address phase
  ////////////////////////////////////////////////////////////

  always_comb begin
    case (request.access)
      ACC_MEMORY: begin
        addrCbe.cmd = request.read ? CMD_MEM_READ : CMD_MEM_WRITE;
        adLow       = request.addrLow;
      end
      ACC_IO: begin
        addrCbe.cmd = request.read ? CMD_IO_READ : CMD_IO_WRITE;
        adLow       = request.addrLow;
      end
      default: begin
        // Config type 0 or 1
        addrCbe.cmd = request.read ? CMD_CFG_READ : CMD_CFG_WRITE;
        // Config type goes out on AD[1:0]
        adLow       = request.access;
      end
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Data phase
  ////////////////////////////////////////////////////////////

  // Reads take every lane
  // Writes use the CPU lane enables as given
  always_comb begin
    dataCbe.lanes = request.read ? byteEnables'(`PCI_LANES_ALL) : request.lanes;
  end

endmodule

`default_nettype wire

// ==== pciCycleCatch.sv ====
// PCI cycle start catch

`timescale 1ns/1ps
`default_nettype none

module pciCycleCatch import pciBridgePkg::*; (
  input  wire             CLK40,
  input  wire             RESETn,
  input  wire             TSn,
  input  wire             BPRO_ENn,
  input  wire             RnW,
  input  wire             BURST,
  input  wire accessType  pciat,
  input  wire [1:0]       A,
  input  wire byteEnables lanes,
  input  wire             accept,
  output logic            pending,
  output pciRequest       request
);

  // One cycle flag for a start seen on the CPU bus
  logic startSeen;
  logic takeStart;

  // Transfer start into the PCI window
  // Blocked while an earlier start is still waiting
  assign takeStart = !TSn && !BPRO_ENn && !startSeen && !pending;

  always_ff @(posedge CLK40) begin
    if (!RESETn) begin
      startSeen <= 1'b0;
      pending   <= 1'b0;
    end else begin
      startSeen <= takeStart;
      // Hold until the state machine takes the request
      pending   <= startSeen || (pending && !accept);
    end
  end

  // Request fields, sampled on the same edge as the start
  always_ff @(posedge CLK40) begin
    if (takeStart) begin
      request.access  <= pciat;
      request.read    <= RnW;
      request.addrLow <= A;
      request.burst   <= BURST;
      request.lanes   <= lanes;
    end
  end

endmodule

`default_nettype wire

// ==== pciInitiatorFsm.sv ====
// PCI initiator state machine
// Address phase, data beats and master abort

`timescale 1ns/1ps
`default_nettype none

`include "pciBridge_consts.svh"

module pciInitiatorFsm import pciBridgePkg::*; (
  input  wire         CLK40,
  input  wire         RESETn,
  input  wire         pending,
  input  wire         burst,
  input  wire cbeWord addrCbe,
  input  wire cbeWord dataCbe,
  input  wire [1:0]   adLowIn,
  input  wire         DEVSELn,
  input  wire         TRDYn,
  output logic        accept,
  output logic        FRAMEn,
  output logic        IRDYn,
  output cbeWord      CBE,
  output logic [1:0]  AD,
  output logic        adOe,
  output logic        pciCycleN,
  output logic        transferAckN,
  output logic        transferErrN
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_ADDR,
    ST_DATA,
    ST_TURN
  } fsmState;

  fsmState                  state;
  // Beats still to move in this cycle
  logic [`PCI_COUNT_W-1:0]  beatsLeft;
  // Data phase cycles spent without DEVSELn
  logic [`PCI_COUNT_W-1:0]  devselWait;
  logic                     beatDone;
  logic                     abortNow;

  // Take a waiting request only from idle
  assign accept = (state == ST_IDLE) && pending;

  // Target and initiator both ready
  assign beatDone = (state == ST_DATA) && !DEVSELn && !TRDYn && !IRDYn;

  // No target claimed the cycle in time
  assign abortNow = (state == ST_DATA) && DEVSELn &&
                    (devselWait == `PCI_DEVSEL_TIMEOUT - 3'd1);

  ////////////////////////////////////////////////////////////
  // State and bus outputs
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK40) begin
    if (!RESETn) begin
      state        <= ST_IDLE;
      FRAMEn       <= 1'b1;
      IRDYn        <= 1'b1;
      adOe         <= 1'b0;
      pciCycleN    <= 1'b1;
      transferAckN <= 1'b1;
      transferErrN <= 1'b1;
      CBE.cmd      <= CMD_MEM_READ;
      AD           <= 2'b00;
      beatsLeft    <= '0;
      devselWait   <= '0;
    end else begin
      // CPU strobes last one cycle
      transferAckN <= 1'b1;
      transferErrN <= 1'b1;
      case (state)
        ST_IDLE: begin
          if (accept) begin
            // Address phase on the bus
            state     <= ST_ADDR;
            FRAMEn    <= 1'b0;
            pciCycleN <= 1'b0;
            adOe      <= 1'b1;
            CBE       <= addrCbe;
            AD        <= adLowIn;
            beatsLeft <= burst ? `PCI_BURST_BEATS : 3'd1;
          end
        end
        ST_ADDR: begin
          // First data phase, AD released
          state      <= ST_DATA;
          IRDYn      <= 1'b0;
          adOe       <= 1'b0;
          CBE        <= dataCbe;
          FRAMEn     <= (beatsLeft == 3'd1);
          devselWait <= '0;
        end
        ST_DATA: begin
          if (abortNow) begin
            // Master abort
            transferErrN <= 1'b0;
            FRAMEn       <= 1'b1;
            IRDYn        <= 1'b1;
            state        <= ST_TURN;
          end else if (beatDone) begin
            transferAckN <= 1'b0;
            beatsLeft    <= beatsLeft - 3'd1;
            // Last beat follows, so FRAMEn goes high now
            if (beatsLeft == 3'd2) begin
              FRAMEn <= 1'b1;
            end
            if (beatsLeft == 3'd1) begin
              IRDYn <= 1'b1;
              state <= ST_TURN;
            end
          end else if (DEVSELn) begin
            devselWait <= devselWait + 3'd1;
          end
        end
        ST_TURN: begin
          // One idle clock before the bus is free again
          pciCycleN <= 1'b1;
          CBE.cmd   <= CMD_MEM_READ;
          state     <= ST_IDLE;
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

endmodule

`default_nettype wire
